// File: source/cdc_pkg.sv
`default_nettype none

package cdc_pkg;

    //////////////////////////////
    // Widths.
    //////////////////////////////

    localparam int WORD_W      = 8;
    localparam int CNT_W       = 8;

    // Flops per crossing, each direction.
    localparam int SYNC_STAGES = 3;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [CNT_W-1:0]  overrun_cnt_t;   // Saturates at all ones.

    // Receive side hold state.
    typedef enum logic {
        RX_IDLE,
        RX_HOLD
    } rx_state_e;

endpackage

`default_nettype wire

// File: source/value_deliver.sv
`timescale 1ns/100ps
`default_nettype none

module value_deliver import cdc_pkg::*; (
    input  logic  clk_a,
    input  logic  rst_a_n,
    input  logic  clk_b,
    input  logic  rst_b_n,
    input  logic  pulse_in,
    input  word_t value_in,
    output logic  busy,
    output logic  drop_strobe,
    output logic  pulse_out,
    output word_t value_out
);

    logic                   accept;
    logic                   launch_tgl;
    word_t                  hold_word;
    logic [SYNC_STAGES-1:0] tgl_sync_b;
    logic                   tgl_seen_b;
    logic                   tgl_edge_b;
    logic [SYNC_STAGES-1:0] ret_sync_a;

    //////////////////////////////
    // Launch side, clk_a.
    //////////////////////////////

    assign accept      = pulse_in & ~busy;
    assign drop_strobe = pulse_in & busy;      // Word already in flight.

    always_ff @(posedge clk_a or negedge rst_a_n) begin
        if (!rst_a_n) begin
            launch_tgl <= 1'b0;
        end else if (accept) begin
            launch_tgl <= ~launch_tgl;
        end
    end

    // Stays put until the toggle comes back.
    always_ff @(posedge clk_a) begin
        if (accept) begin
            hold_word <= value_in;
        end
    end

    // Return of the seen toggle.
    always_ff @(posedge clk_a or negedge rst_a_n) begin
        if (!rst_a_n) begin
            ret_sync_a <= '0;
        end else begin
            ret_sync_a <= {ret_sync_a[SYNC_STAGES-2:0], tgl_seen_b};
        end
    end

    assign busy = launch_tgl ^ ret_sync_a[SYNC_STAGES-1];

    //////////////////////////////
    // Capture side, clk_b.
    //////////////////////////////

    always_ff @(posedge clk_b or negedge rst_b_n) begin
        if (!rst_b_n) begin
            tgl_sync_b <= '0;
        end else begin
            tgl_sync_b <= {tgl_sync_b[SYNC_STAGES-2:0], launch_tgl};
        end
    end

    assign tgl_edge_b = tgl_sync_b[SYNC_STAGES-1] ^ tgl_seen_b;

    always_ff @(posedge clk_b or negedge rst_b_n) begin
        if (!rst_b_n) begin
            tgl_seen_b <= 1'b0;
            pulse_out  <= 1'b0;
        end else begin
            tgl_seen_b <= tgl_sync_b[SYNC_STAGES-1];
            pulse_out  <= tgl_edge_b;          // One cycle per toggle edge.
        end
    end

    // Holding register is quiet here, so a plain load is safe.
    always_ff @(posedge clk_b) begin
        if (tgl_edge_b) begin
            value_out <= hold_word;
        end
    end

    //////////////////////////////
    // Checks.
    //////////////////////////////

    // The clk_b capture relies on this word being frozen while in flight.
    hold_stable_while_busy: assert property (
        @(posedge clk_a) disable iff (!rst_a_n)
        busy |=> $stable(hold_word)
    );

endmodule

`default_nettype wire

// File: source/value_transmitter.sv
`timescale 1ns/100ps
`default_nettype none

module value_transmitter import cdc_pkg::*; (
    input  logic  clk_a,
    input  logic  rst_a_n,
    input  logic  clk_b,
    input  logic  rst_b_n,
    input  logic  pulse_in,
    input  word_t value_in,
    input  logic  value_out_ack,
    output logic  busy,
    output logic  drop_strobe,
    output logic  pulse_out,
    output word_t value_out
);

    logic      pulse_in_ff;
    word_t     value_in_ff;
    logic      pulse_int;
    word_t     value_int;
    rx_state_e rx_state;
    logic      clear_req;

    //////////////////////////////
    // Input registers, clk_a.
    //////////////////////////////

    always_ff @(posedge clk_a or negedge rst_a_n) begin
        if (!rst_a_n) begin
            pulse_in_ff <= 1'b0;
        end else begin
            pulse_in_ff <= pulse_in;
        end
    end

    always_ff @(posedge clk_a) begin
        if (pulse_in) begin
            value_in_ff <= value_in;           // Captured with the strobe.
        end
    end

    value_deliver u_value_deliver (
        .clk_a       (clk_a),
        .rst_a_n     (rst_a_n),
        .clk_b       (clk_b),
        .rst_b_n     (rst_b_n),
        .pulse_in    (pulse_in_ff),
        .value_in    (value_in_ff),
        .busy        (busy),
        .drop_strobe (drop_strobe),
        .pulse_out   (pulse_int),
        .value_out   (value_int)
    );

    //////////////////////////////
    // Output registers, clk_b.
    //////////////////////////////

    // Delivery wins over ack.
    assign clear_req = value_out_ack & ~pulse_int & (rx_state == RX_HOLD);

    always_ff @(posedge clk_b or negedge rst_b_n) begin
        if (!rst_b_n) begin
            pulse_out <= 1'b0;
        end else begin
            pulse_out <= pulse_int;
        end
    end

    always_ff @(posedge clk_b or negedge rst_b_n) begin
        if (!rst_b_n) begin
            rx_state  <= RX_IDLE;
            value_out <= '0;
        end else if (pulse_int) begin
            rx_state  <= RX_HOLD;
            value_out <= value_int;
        end else if (clear_req) begin
            rx_state  <= RX_IDLE;
            value_out <= '0;
        end
    end

    //////////////////////////////
    // Checks.
    //////////////////////////////

    pulse_out_single: assert property (
        @(posedge clk_b) disable iff (!rst_b_n)
        pulse_out |=> !pulse_out
    );

    // Idle state must already read zero for this to hold.
    ack_clears_word: assert property (
        @(posedge clk_b) disable iff (!rst_b_n)
        (value_out_ack && !pulse_int) |=> (value_out == '0)
    );

endmodule

`default_nettype wire

// File: source/overrun_monitor.sv
`timescale 1ns/100ps
`default_nettype none

module overrun_monitor import cdc_pkg::*; (
    input  logic         clk_a,
    input  logic         rst_a_n,
    input  logic         drop_strobe,
    output overrun_cnt_t overrun_count
);

    overrun_cnt_t count_q;
    overrun_cnt_t count_nxt;
    logic         saturated;

    //////////////////////////////
    // Dropped strobe count.
    //////////////////////////////

    assign saturated = (count_q == '1);

    always_comb begin
        count_nxt = count_q;
        if (drop_strobe && !saturated) begin
            count_nxt = count_q + overrun_cnt_t'(1);
        end
    end

    always_ff @(posedge clk_a or negedge rst_a_n) begin
        if (!rst_a_n) begin
            count_q <= '0;
        end else begin
            count_q <= count_nxt;
        end
    end

    assign overrun_count = count_q;    // Status only.

    //////////////////////////////
    // Checks.
    //////////////////////////////

    // Monotonic, including the wrap a plain counter would make.
    count_monotonic: assert property (
        @(posedge clk_a) disable iff (!rst_a_n)
        overrun_count >= $past(overrun_count)
    );

endmodule

`default_nettype wire

// File: source/cdc_value_link.sv
`timescale 1ns/100ps
`default_nettype none

module cdc_value_link import cdc_pkg::*; (
    input  logic         clk_a,
    input  logic         rst_a_n,
    input  logic         clk_b,
    input  logic         rst_b_n,
    input  logic         pulse_in,
    input  word_t        value_in,
    input  logic         value_out_ack,
    output logic         busy,
    output logic         pulse_out,
    output word_t        value_out,
    output overrun_cnt_t overrun_count
);

    logic drop_strobe;    // clk_a, one cycle.

    //////////////////////////////
    // Datapath.
    //////////////////////////////

    value_transmitter u_value_transmitter (
        .clk_a         (clk_a),
        .rst_a_n       (rst_a_n),
        .clk_b         (clk_b),
        .rst_b_n       (rst_b_n),
        .pulse_in      (pulse_in),
        .value_in      (value_in),
        .value_out_ack (value_out_ack),
        .busy          (busy),
        .drop_strobe   (drop_strobe),
        .pulse_out     (pulse_out),
        .value_out     (value_out)
    );

    //////////////////////////////
    // Status.
    //////////////////////////////

    overrun_monitor u_overrun_monitor (
        .clk_a         (clk_a),
        .rst_a_n       (rst_a_n),
        .drop_strobe   (drop_strobe),
        .overrun_count (overrun_count)
    );

endmodule

`default_nettype wire

// File: test/tb_link_checker.sv
`timescale 1ns/100ps
`default_nettype none

module tb_link_checker import cdc_pkg::*; (
    input  logic         clk_a,
    input  logic         rst_a_n,
    input  logic         clk_b,
    input  logic         rst_b_n,
    input  logic         pulse_in,
    input  word_t        value_in,
    input  logic         value_out_ack,
    input  logic         busy,
    input  logic         pulse_out,
    input  word_t        value_out,
    input  overrun_cnt_t overrun_count,
    input  logic [1:0]   phase,
    input  logic         final_check,
    output int           mismatch_count,
    output int           other_count
);

    word_t     sent_q[$];
    int        strobes;
    int        deliveries;
    logic      seen_delivery;
    logic      pin_d;
    logic      busy_d;
    logic      expect_busy;
    logic      pulse_d;
    logic      ack_d;
    word_t     exp_out;
    rx_state_e exp_state;

    initial begin
        mismatch_count  = 0;
        other_count     = 0;
        strobes         = 0;
        deliveries      = 0;
        seen_delivery   = 1'b0;
        pin_d           = 1'b0;
        busy_d          = 1'b0;
        expect_busy     = 1'b0;
        pulse_d         = 1'b0;
        ack_d           = 1'b0;
        exp_out         = '0;
        exp_state       = RX_IDLE;
    end

    //////////////////////////////
    // Reset values.
    //////////////////////////////

    initial begin
        wait (rst_a_n && rst_b_n);
        @(posedge clk_a);
        if (busy !== 1'b0 || pulse_out !== 1'b0 || value_out !== '0 || overrun_count !== '0) begin
            $display("Outputs not zero after reset at %0t", $time);
            other_count++;
        end
    end

    //////////////////////////////
    // Sending side, clk_a.
    //////////////////////////////

    always @(posedge clk_a) begin
        if (rst_a_n) begin
            if (pulse_out) begin
                seen_delivery = 1'b1;         // Pulse is wider than a clk_a period.
            end
            if (expect_busy && !busy) begin
                $display("busy did not rise after an accepted strobe at %0t", $time);
                other_count++;
            end
            if (busy_d && !busy && !seen_delivery) begin
                $display("busy dropped before its word was delivered at %0t", $time);
                other_count++;
            end
            if (phase == 2'd1 && overrun_count != '0) begin
                $display("Mismatch at %0t: overrun_count expected 0 got %0d",
                         $time, overrun_count);
                mismatch_count++;
            end
            expect_busy = pin_d && !busy;     // Accept happens at this edge.
            if (expect_busy) begin
                seen_delivery = 1'b0;
            end
            if (pulse_in) begin
                sent_q.push_back(value_in);
                strobes++;
            end
            pin_d  = pulse_in;
            busy_d = busy;
        end
    end

    //////////////////////////////
    // Receiving side, clk_b.
    //////////////////////////////

    always @(posedge clk_b) begin
        int skipped;
        word_t head;
        skipped = 0;
        if (rst_b_n) begin
            if (pulse_out && pulse_d) begin
                $display("pulse_out high on two consecutive clk_b edges at %0t", $time);
                other_count++;
            end
            if (pulse_out) begin
                head = (sent_q.size() > 0) ? sent_q[0] : '0;
                while (sent_q.size() > 0 && sent_q[0] != value_out) begin
                    void'(sent_q.pop_front());
                    skipped++;
                end
                if (sent_q.size() == 0) begin
                    $display("Mismatch at %0t: value_out expected %h got %h",
                             $time, head, value_out);
                    mismatch_count++;
                    exp_out = head;
                end else begin
                    exp_out = sent_q.pop_front();
                end
                if (phase == 2'd1 && skipped > 0) begin
                    $display("Mismatch at %0t: value_out expected %h got %h",
                             $time, head, value_out);
                    mismatch_count++;
                end
                deliveries++;
                exp_state = RX_HOLD;
            end else if (ack_d && exp_state == RX_HOLD) begin
                exp_out   = '0;              // Cleared by last ack.
                exp_state = RX_IDLE;
            end
            if (value_out !== exp_out) begin
                $display("Mismatch at %0t: value_out expected %h got %h",
                         $time, exp_out, value_out);
                mismatch_count++;
            end
            pulse_d = pulse_out;
            ack_d   = value_out_ack;
        end
    end

    // Every strobe is either delivered or counted as dropped.
    always @(posedge final_check) begin
        if (deliveries + int'(overrun_count) != strobes) begin
            $display("Mismatch at %0t: deliveries+overrun_count expected %0d got %0d",
                     $time, strobes, deliveries + int'(overrun_count));
            mismatch_count++;
        end
    end

endmodule

`default_nettype wire

// File: test/tb_cdc_value_link.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cdc_value_link import cdc_pkg::*; ();

    localparam int N_SPACED = 20;
    localparam int N_DENSE  = 200;
    localparam int N_ACKED  = 40;
    localparam int N_TOTAL  = N_SPACED + N_DENSE + N_ACKED;
    localparam int MARGIN   = 400 * (SYNC_STAGES + 2);   // clk_a cycles.

    logic         clk_a;
    logic         clk_b;
    logic         rst_a_n;
    logic         rst_b_n;
    logic         pulse_in;
    word_t        value_in;
    logic         value_out_ack;
    logic         busy;
    logic         pulse_out;
    word_t        value_out;
    overrun_cnt_t overrun_count;
    logic [1:0]   phase;
    logic         final_check;
    logic [15:0]  lfsr;
    int           mismatch_count;
    int           other_count;

    always #2.0 clk_a = ~clk_a;
    always #3.5 clk_b = ~clk_b;

    cdc_value_link dut (
        .clk_a         (clk_a),
        .rst_a_n       (rst_a_n),
        .clk_b         (clk_b),
        .rst_b_n       (rst_b_n),
        .pulse_in      (pulse_in),
        .value_in      (value_in),
        .value_out_ack (value_out_ack),
        .busy          (busy),
        .pulse_out     (pulse_out),
        .value_out     (value_out),
        .overrun_count (overrun_count)
    );

    tb_link_checker u_checker (
        .clk_a          (clk_a),
        .rst_a_n        (rst_a_n),
        .clk_b          (clk_b),
        .rst_b_n        (rst_b_n),
        .pulse_in       (pulse_in),
        .value_in       (value_in),
        .value_out_ack  (value_out_ack),
        .busy           (busy),
        .pulse_out      (pulse_out),
        .value_out      (value_out),
        .overrun_count  (overrun_count),
        .phase          (phase),
        .final_check    (final_check),
        .mismatch_count (mismatch_count),
        .other_count    (other_count)
    );

    // Taps 16,14,13,11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
    endtask

    task automatic send_word(input int gap);
        logic [15:0] r;
        take_bits(8, r);
        @(posedge clk_a);
        pulse_in <= 1'b1;
        value_in <= word_t'(r[7:0]);
        @(posedge clk_a);
        pulse_in <= 1'b0;
        repeat (gap) @(posedge clk_a);
    endtask

    // Random acks, about one in four clk_b cycles.
    always @(posedge clk_b) begin
        logic [15:0] r;
        if (phase == 2'd3) begin
            take_bits(2, r);
            value_out_ack <= (r[1:0] == 2'b00);
        end else begin
            value_out_ack <= 1'b0;
        end
    end

    initial begin
        #(4.0 * (N_TOTAL * 30 + MARGIN));
        $display("Watchdog expired before the test sequence finished");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        logic [15:0] r;
        clk_a = 1'b0;
        clk_b = 1'b0;
        rst_a_n = 1'b0;
        rst_b_n = 1'b0;
        pulse_in = 1'b0;
        value_in = '0;
        value_out_ack = 1'b0;
        phase = 2'd0;
        final_check = 1'b0;
        lfsr = 16'd33837;
        repeat (8) @(posedge clk_a);
        rst_a_n <= 1'b1;
        rst_b_n <= 1'b1;
        repeat (4) @(posedge clk_a);

        ////////////////////////////// Spaced.
        phase <= 2'd1;
        for (int i = 0; i < N_SPACED; i++) begin
            take_bits(3, r);
            send_word(30 + int'(r[2:0]));
        end
        ////////////////////////////// Dense.
        phase <= 2'd2;
        for (int i = 0; i < N_DENSE; i++) begin
            take_bits(2, r);
            send_word(int'(r[1:0]));
        end
        ////////////////////////////// Acks.
        phase <= 2'd3;
        for (int i = 0; i < N_ACKED; i++) begin
            take_bits(4, r);
            send_word(4 + int'(r[3:0]));
        end
        phase <= 2'd0;

        while (busy) @(posedge clk_a);
        repeat (20) @(posedge clk_a);
        final_check <= 1'b1;
        repeat (2) @(posedge clk_a);
        $display("Errors: mismatches=%0d other=%0d", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
source/cdc_pkg.sv
source/value_deliver.sv
source/value_transmitter.sv
source/overrun_monitor.sv
source/cdc_value_link.sv
test/tb_link_checker.sv
test/tb_cdc_value_link.sv

// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_cdc_value_link
RTL_TOP    = cdc_value_link
FLIST      = flist.f
OBJ_DIR    = obj_dir
LOG        = sim.log

RTL_FILES  = $(filter source/%,$(shell cat $(FLIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then exit 1; fi
	@grep -q "TB PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
